/* logic/hacd_axi_pkg.sv */
// AXI bus widths and response codes for the page-read manager.
// Shared by the read port, the top level and the tests.

package hacd_axi_pkg;

	// byte address width on the read channel
	localparam int unsigned axi_addr_w = 40;

	// one beat carries a whole 64-byte table line
	localparam int unsigned axi_data_w = 512;

	localparam int unsigned axi_resp_w = 2;

	// rresp codes
	localparam logic [axi_resp_w-1:0] resp_okay = 2'b00;
	// slave error, the code used to flag a failed read
	localparam logic [axi_resp_w-1:0] resp_slverr = 2'b10;

	// 4 KiB pages, so page number is the address above bit 11
	localparam int unsigned page_w = axi_addr_w - 12;

endpackage

/* logic/hacd_tbl_pkg.sv */
// Layouts of the translation table and list entries kept in memory.
// Also holds the status and list codes and the 64-byte line union.

package hacd_tbl_pkg;

	// translation status of a host page
	typedef enum logic [1:0] {
		sts_dalloc = 2'd0,
		sts_uncomp = 2'd1,
		sts_incomp = 2'd2,
		sts_comp   = 2'd3
	} att_sts_t;

	// one ATT entry, eight per line, way in the low bits
	typedef struct packed {
		logic [64-hacd_axi_pkg::page_w-3:0] rsvd;
		att_sts_t                           sts;
		logic [hacd_axi_pkg::page_w-1:0]    way;
	} att_entry_t;

	// ids into the list table, id 0 is never used
	typedef logic [15:0] list_id_t;

	// one list entry, four per line
	typedef struct packed {
		logic [128-hacd_axi_pkg::page_w-2*$bits(list_id_t)-1:0] rsvd;
		list_id_t                                               prev;
		list_id_t                                               next;
		logic [hacd_axi_pkg::page_w-1:0]                        ppa;
	} list_entry_t;

	// which list an entry sits on
	typedef enum logic [1:0] {
		lst_free   = 2'd0,
		lst_uncomp = 2'd1,
		lst_comp   = 2'd2
	} list_sel_t;

	// a 64-byte line seen as ATT entries or as list entries
	// index 0 is the lowest addressed slot
	typedef union packed {
		att_entry_t [7:0]  att;
		list_entry_t [3:0] lst;
	} tbl_line_u;

endpackage

/* logic/tbl_addr_gen.sv */
// Address generator for table reads.
// Maps a host page to its ATT line and slot, and the free-list head to its line and slot.
`timescale 1ns/10ps

module tbl_addr_gen #(
	parameter logic [hacd_axi_pkg::axi_addr_w-1:0] att_start  = '0,
	parameter logic [hacd_axi_pkg::axi_addr_w-1:0] list_start = '0,
	parameter logic [hacd_axi_pkg::page_w-1:0]     hppa_base  = '0
) (
	input  logic [hacd_axi_pkg::page_w-1:0]     hppa,
	input  hacd_tbl_pkg::list_id_t              head,
	input  logic                                is_list,
	output logic [hacd_axi_pkg::axi_addr_w-1:0] addr,
	output hacd_tbl_pkg::list_id_t              att_id,
	output logic [2:0]                          att_slot,
	output logic [1:0]                          list_slot
);

	localparam int unsigned aw = hacd_axi_pkg::axi_addr_w;
	localparam int unsigned pw = hacd_axi_pkg::page_w;
	localparam int unsigned iw = $bits(hacd_tbl_pkg::list_id_t);

	logic [pw-1:0]          att_off;
	hacd_tbl_pkg::list_id_t head_off;
	logic [aw-1:0]          att_line;
	logic [aw-1:0]          list_line;

	// zero-based index into each table
	assign att_off  = hppa - hppa_base;
	assign head_off = head - iw'(1);

	// entry ids are one-based
	assign att_id = att_off[iw-1:0] + iw'(1);

	// eight ATT entries per 64-byte line
	assign att_slot = att_off[2:0];
	assign att_line = att_start + aw'({att_off[pw-1:3], 6'd0});

	// four list entries per line
	assign list_slot = head_off[1:0];
	assign list_line = list_start + aw'({head_off[iw-1:2], 6'd0});

	assign addr = is_list ? list_line : att_line;

endmodule

/* logic/axi_rd_port.sv */
// Single-beat AXI read master used for table line fetches.
// A start pulse issues one read; the line is kept until the next read returns.
`timescale 1ns/10ps

module axi_rd_port (
	input  logic                                clk_i,
	input  logic                                rst_ni,
	input  logic                                start,
	input  logic [hacd_axi_pkg::axi_addr_w-1:0] addr,
	// address channel
	output logic [hacd_axi_pkg::axi_addr_w-1:0] araddr,
	output logic                                arvalid,
	input  logic                                arready,
	// data channel
	input  logic                                rvalid,
	input  logic [hacd_axi_pkg::axi_data_w-1:0] rdata,
	input  logic [hacd_axi_pkg::axi_resp_w-1:0] rresp,
	input  logic                                rlast,
	output logic                                rready,
	// to the controller
	output logic                                done,
	output logic                                err,
	output hacd_tbl_pkg::tbl_line_u             line
);

	logic wait_r;
	logic rd_fire;
	logic resp_ok;

	// only beats of an issued read count
	assign rd_fire = wait_r & rvalid & rready;
	assign resp_ok = rresp == hacd_axi_pkg::resp_okay;

	// done and err share the beat cycle, line is valid from the next one
	assign done = rd_fire & rlast & resp_ok;
	assign err  = rd_fire & ~resp_ok;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			arvalid <= 1'b0;
			wait_r  <= 1'b0;
			rready  <= 1'b0;
		end else begin
			// never back-pressure, reads are only issued when wanted
			rready <= 1'b1;
			if (start) begin
				arvalid <= 1'b1;
			end else if (arvalid && arready) begin
				arvalid <= 1'b0;
			end
			if (arvalid && arready) begin
				wait_r <= 1'b1;
			end else if (rd_fire && (rlast || !resp_ok)) begin
				wait_r <= 1'b0;
			end
		end
	end

	// address held from start until arready
	always_ff @(posedge clk_i) begin
		if (start) begin
			araddr <= addr;
		end
		if (done) begin
			line <= hacd_tbl_pkg::tbl_line_u'(rdata);
		end
	end

endmodule

/* logic/line_decode.sv */
// Slot select on a captured table line.
// Gives the ATT entry and the list entry at the requested slots, combinationally.
`timescale 1ns/10ps

module line_decode (
	input  hacd_tbl_pkg::tbl_line_u   line,
	input  logic [2:0]                att_slot,
	input  logic [1:0]                list_slot,
	output hacd_tbl_pkg::att_entry_t  att_entry,
	output hacd_tbl_pkg::list_entry_t list_entry
);

	// ATT view, eight 64-bit entries
	always_comb begin
		att_entry = line.att[att_slot];
	end

	// list view of the same word, four 128-bit entries
	always_comb begin
		list_entry = line.lst[list_slot];
	end

endmodule

/* logic/pgrd_ctrl.sv */
// Page-read control FSM.
// Sequences ATT lookup, free-list pop, table-update handoff and the sticky bus error.
`timescale 1ns/10ps

module pgrd_ctrl #(
	parameter logic [hacd_axi_pkg::page_w-1:0] hppa_base = '0
) (
	input  logic                              clk_i,
	input  logic                              rst_ni,
	// lookup request
	input  logic                              lkup_valid,
	input  logic [hacd_axi_pkg::page_w-1:0]   lkup_hppa,
	output logic                              lkup_ready,
	input  hacd_tbl_pkg::list_id_t            free_head,
	input  hacd_tbl_pkg::list_id_t            free_tail,
	// datapath control
	output logic                              rd_start,
	output logic                              rd_is_list,
	output logic [hacd_axi_pkg::page_w-1:0]   rd_hppa,
	input  logic                              rd_done,
	input  logic                              rd_err,
	input  hacd_tbl_pkg::att_entry_t          att_entry,
	input  hacd_tbl_pkg::list_entry_t         list_entry,
	input  hacd_tbl_pkg::list_id_t            att_id,
	// translation result
	output logic                              trnsl_valid,
	output logic [hacd_axi_pkg::page_w-1:0]   trnsl_ppa,
	output hacd_tbl_pkg::att_sts_t            trnsl_sts,
	output logic                              trnsl_allow,
	// table update to the page-write manager
	output logic                              upd_valid,
	output hacd_tbl_pkg::list_id_t            upd_att_id,
	output hacd_tbl_pkg::list_id_t            upd_tol_id,
	output hacd_tbl_pkg::list_sel_t           upd_src,
	output hacd_tbl_pkg::list_sel_t           upd_dst,
	output hacd_tbl_pkg::list_entry_t         upd_entry,
	input  logic                              upd_ready,
	output logic                              bus_error
);

	typedef enum logic [2:0] {
		st_idle,
		st_att_rd,
		st_att_dec,
		st_lst_rd,
		st_alloc,
		st_upd,
		st_bus_err
	} state_t;

	state_t                          state_q;
	state_t                          state_d;
	logic [hacd_axi_pkg::page_w-1:0] hppa_q;
	logic                            lkup_fire;
	logic                            free_empty;
	logic                            sts_hit;
	logic                            need_alloc;

	assign lkup_fire  = lkup_valid & lkup_ready;
	assign free_empty = free_head == free_tail;

	// uncompressed and incompressible pages are directly usable
	assign sts_hit = (att_entry.sts == hacd_tbl_pkg::sts_uncomp) ||
		(att_entry.sts == hacd_tbl_pkg::sts_incomp);

	// deallocated page with something left on the free list
	assign need_alloc = (state_q == st_att_dec) && !free_empty &&
		(att_entry.sts == hacd_tbl_pkg::sts_dalloc);

	// ready drops for the cycle of the result pulse
	assign lkup_ready = (state_q == st_idle) && !trnsl_valid;

	// start is combinational so arvalid follows acceptance by one cycle
	assign rd_start   = lkup_fire | need_alloc;
	assign rd_is_list = state_q == st_att_dec;
	// address from the live request while idle, from the latch after
	assign rd_hppa    = (state_q == st_idle) ? lkup_hppa : hppa_q;

	assign bus_error = state_q == st_bus_err;

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: begin
				if (lkup_fire) begin
					state_d = st_att_rd;
				end
			end
			st_att_rd: begin
				if (rd_err) begin
					state_d = st_bus_err;
				end else if (rd_done) begin
					state_d = st_att_dec;
				end
			end
			st_att_dec: begin
				// comp and empty free list both end with access denied
				state_d = need_alloc ? st_lst_rd : st_idle;
			end
			st_lst_rd: begin
				if (rd_err) begin
					state_d = st_bus_err;
				end else if (rd_done) begin
					state_d = st_alloc;
				end
			end
			st_alloc: begin
				state_d = st_upd;
			end
			st_upd: begin
				if (upd_ready) begin
					state_d = st_idle;
				end
			end
			// left only through reset
			st_bus_err: begin
				state_d = st_bus_err;
			end
			default: begin
				state_d = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q     <= st_idle;
			trnsl_valid <= 1'b0;
			upd_valid   <= 1'b0;
			// park on the first table page
			hppa_q      <= hppa_base;
		end else begin
			state_q     <= state_d;
			trnsl_valid <= (state_q == st_att_dec) && !need_alloc;
			if (state_q == st_alloc) begin
				upd_valid <= 1'b1;
			end else if (upd_ready) begin
				upd_valid <= 1'b0;
			end
			if (lkup_fire) begin
				hppa_q <= lkup_hppa;
			end
		end
	end

	// result and update payloads
	always_ff @(posedge clk_i) begin
		if (state_q == st_att_dec) begin
			trnsl_ppa   <= att_entry.way;
			trnsl_sts   <= att_entry.sts;
			trnsl_allow <= sts_hit;
		end
		// head entry moves from free to uncompressed list
		if (state_q == st_alloc) begin
			upd_att_id <= att_id;
			upd_tol_id <= free_head;
			upd_src    <= hacd_tbl_pkg::lst_free;
			upd_dst    <= hacd_tbl_pkg::lst_uncomp;
			upd_entry  <= list_entry;
		end
	end

endmodule

/* logic/pgrd_top.sv */
// Page-read manager top level.
// Table base addresses and the first host page are set here and passed down.
`timescale 1ns/10ps

module pgrd_top #(
	parameter logic [hacd_axi_pkg::axi_addr_w-1:0] att_start  = 40'h00_0010_0000,
	parameter logic [hacd_axi_pkg::axi_addr_w-1:0] list_start = 40'h00_0020_0000,
	parameter logic [hacd_axi_pkg::page_w-1:0]     hppa_base  = 28'h008_0000
) (
	input  logic                                clk_i,
	input  logic                                rst_ni,
	input  logic                                lkup_valid,
	input  logic [hacd_axi_pkg::page_w-1:0]     lkup_hppa,
	output logic                                lkup_ready,
	input  hacd_tbl_pkg::list_id_t              free_head,
	input  hacd_tbl_pkg::list_id_t              free_tail,
	output logic [hacd_axi_pkg::axi_addr_w-1:0] araddr,
	output logic                                arvalid,
	input  logic                                arready,
	input  logic                                rvalid,
	input  logic [hacd_axi_pkg::axi_data_w-1:0] rdata,
	input  logic [hacd_axi_pkg::axi_resp_w-1:0] rresp,
	input  logic                                rlast,
	output logic                                rready,
	output logic                                trnsl_valid,
	output logic [hacd_axi_pkg::page_w-1:0]     trnsl_ppa,
	output hacd_tbl_pkg::att_sts_t              trnsl_sts,
	output logic                                trnsl_allow,
	output logic                                upd_valid,
	output hacd_tbl_pkg::list_id_t              upd_att_id,
	output hacd_tbl_pkg::list_id_t              upd_tol_id,
	output hacd_tbl_pkg::list_sel_t             upd_src,
	output hacd_tbl_pkg::list_sel_t             upd_dst,
	output hacd_tbl_pkg::list_entry_t           upd_entry,
	input  logic                                upd_ready,
	output logic                                bus_error
);

	logic                                rd_start;
	logic                                rd_is_list;
	logic [hacd_axi_pkg::page_w-1:0]     rd_hppa;
	logic [hacd_axi_pkg::axi_addr_w-1:0] rd_addr;
	logic                                rd_done;
	logic                                rd_err;
	hacd_tbl_pkg::tbl_line_u             rd_line;
	hacd_tbl_pkg::list_id_t              att_id;
	logic [2:0]                          att_slot;
	logic [1:0]                          list_slot;
	hacd_tbl_pkg::att_entry_t            att_entry;
	hacd_tbl_pkg::list_entry_t           list_entry;

	pgrd_ctrl #(
		.hppa_base (hppa_base)
	) ctrl0 (
		.clk_i, .rst_ni,
		.lkup_valid, .lkup_hppa, .lkup_ready, .free_head, .free_tail,
		.rd_start, .rd_is_list, .rd_hppa, .rd_done, .rd_err,
		.att_entry, .list_entry, .att_id,
		.trnsl_valid, .trnsl_ppa, .trnsl_sts, .trnsl_allow,
		.upd_valid, .upd_att_id, .upd_tol_id, .upd_src, .upd_dst, .upd_entry, .upd_ready,
		.bus_error
	);

	tbl_addr_gen #(
		.att_start  (att_start),
		.list_start (list_start),
		.hppa_base  (hppa_base)
	) addr0 (
		.hppa      (rd_hppa),
		.head      (free_head),
		.is_list   (rd_is_list),
		.addr      (rd_addr),
		.att_id    (att_id),
		.att_slot  (att_slot),
		.list_slot (list_slot)
	);

	axi_rd_port rd0 (
		.clk_i, .rst_ni,
		.start   (rd_start),
		.addr    (rd_addr),
		.araddr, .arvalid, .arready,
		.rvalid, .rdata, .rresp, .rlast, .rready,
		.done    (rd_done),
		.err     (rd_err),
		.line    (rd_line)
	);

	line_decode dec0 (
		.line       (rd_line),
		.att_slot   (att_slot),
		.list_slot  (list_slot),
		.att_entry  (att_entry),
		.list_entry (list_entry)
	);

endmodule

/* tests/pgrd_chk.sv */
// Concurrent assertions on the page-read manager handshakes.
// Bound into pgrd_top, checks the AXI address, update and result rules.
`timescale 1ns/10ps

module pgrd_chk (
	input logic                                clk_i,
	input logic                                rst_ni,
	input logic [hacd_axi_pkg::axi_addr_w-1:0] araddr,
	input logic                                arvalid,
	input logic                                arready,
	input logic                                upd_valid,
	input logic                                upd_ready,
	input hacd_tbl_pkg::list_id_t              upd_att_id,
	input hacd_tbl_pkg::list_id_t              upd_tol_id,
	input hacd_tbl_pkg::list_sel_t             upd_src,
	input hacd_tbl_pkg::list_sel_t             upd_dst,
	input hacd_tbl_pkg::list_entry_t           upd_entry,
	input logic                                trnsl_valid,
	input logic                                bus_error
);

	// read by the testbench verdict
	int unsigned fail_cnt = 0;

	// address stays put with arvalid until the slave takes it
	a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		arvalid && !arready |=> arvalid && $stable(araddr))
	else begin
		$error("arvalid dropped or araddr changed before arready");
		fail_cnt++;
	end

	// update packet frozen while the page-write side stalls
	a_upd_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		upd_valid && !upd_ready |=> upd_valid && $stable(upd_att_id) &&
		$stable(upd_tol_id) && $stable(upd_src) && $stable(upd_dst) && $stable(upd_entry))
	else begin
		$error("upd_valid or its payload changed before upd_ready");
		fail_cnt++;
	end

	// result is a single-cycle pulse
	a_trnsl_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
		trnsl_valid |=> !trnsl_valid)
	else begin
		$error("trnsl_valid held longer than one cycle");
		fail_cnt++;
	end

	// sticky until reset
	a_berr_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
		bus_error |=> bus_error)
	else begin
		$error("bus_error fell without a reset");
		fail_cnt++;
	end

endmodule

bind pgrd_top pgrd_chk chk0 (
	.clk_i, .rst_ni,
	.araddr, .arvalid, .arready,
	.upd_valid, .upd_ready, .upd_att_id, .upd_tol_id, .upd_src, .upd_dst, .upd_entry,
	.trnsl_valid, .bus_error
);

/* tests/pgrd_mon.sv */
// Checker for the page-read manager testbench.
// Latches each accepted lookup, recomputes addresses and results, counts mismatches.
`timescale 1ns/10ps

module pgrd_mon #(
	parameter logic [hacd_axi_pkg::axi_addr_w-1:0] att_start  = '0,
	parameter logic [hacd_axi_pkg::axi_addr_w-1:0] list_start = '0,
	parameter logic [hacd_axi_pkg::page_w-1:0]     hppa_base  = '0
) (
	input  logic                                clk_i,
	input  logic                                rst_ni,
	input  logic                                lkup_valid,
	input  logic                                lkup_ready,
	input  logic [hacd_axi_pkg::page_w-1:0]     lkup_hppa,
	input  hacd_tbl_pkg::list_id_t              free_head,
	input  hacd_tbl_pkg::list_id_t              free_tail,
	input  logic [hacd_axi_pkg::axi_addr_w-1:0] araddr,
	input  logic                                arvalid,
	input  logic                                arready,
	input  logic                                rvalid,
	input  logic                                rready,
	input  logic                                trnsl_valid,
	input  logic [hacd_axi_pkg::page_w-1:0]     trnsl_ppa,
	input  hacd_tbl_pkg::att_sts_t              trnsl_sts,
	input  logic                                trnsl_allow,
	input  logic                                upd_valid,
	input  logic                                upd_ready,
	input  hacd_tbl_pkg::list_id_t              upd_att_id,
	input  hacd_tbl_pkg::list_id_t              upd_tol_id,
	input  hacd_tbl_pkg::list_sel_t             upd_src,
	input  hacd_tbl_pkg::list_sel_t             upd_dst,
	input  hacd_tbl_pkg::list_entry_t           upd_entry,
	input  logic                                bus_error,
	// what the current case wrote into memory
	input  hacd_tbl_pkg::att_sts_t              exp_sts,
	input  logic [hacd_axi_pkg::page_w-1:0]     exp_way,
	input  hacd_tbl_pkg::list_entry_t           exp_lentry,
	input  logic                                exp_bad,
	output int unsigned                         err_cnt,
	output int unsigned                         done_cnt
);

	logic [hacd_axi_pkg::page_w-1:0]     off_l;
	logic [hacd_axi_pkg::page_w-1:0]     way_l;
	logic [hacd_axi_pkg::axi_addr_w-1:0] att_addr_l;
	logic [hacd_axi_pkg::axi_addr_w-1:0] list_addr_l;
	hacd_tbl_pkg::list_id_t              head_l;
	hacd_tbl_pkg::att_sts_t              sts_l;
	hacd_tbl_pkg::list_entry_t           lent_l;
	logic                                bad_l;
	logic                                alloc_l;
	logic                                allow_l;
	logic                                upd_valid_q;
	int unsigned                         ar_cnt;
	int unsigned                         beat_age;

	task automatic check_val(input string what, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp) begin
			$display("ERROR %0t: %s is %0h, expected %0h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("ERROR %0t: %s", $time, msg);
		err_cnt++;
	endtask

	always @(posedge clk_i) begin
		if (!rst_ni) begin
			err_cnt     = 0;
			done_cnt    = 0;
			ar_cnt      = 0;
			beat_age    = 0;
			bad_l       = 1'b0;
			alloc_l     = 1'b0;
			upd_valid_q = 1'b0;
		end else begin
			beat_age = beat_age + 1;
			// expected results of the lookup being accepted
			if (lkup_valid && lkup_ready) begin
				off_l   = lkup_hppa - hppa_base;
				head_l  = free_head;
				sts_l   = exp_sts;
				way_l   = exp_way;
				lent_l  = exp_lentry;
				bad_l   = exp_bad;
				alloc_l = (exp_sts == hacd_tbl_pkg::sts_dalloc) && (free_head != free_tail);
				allow_l = (exp_sts == hacd_tbl_pkg::sts_uncomp) ||
					(exp_sts == hacd_tbl_pkg::sts_incomp);
				// eight 8-byte ATT entries and four 16-byte list entries per line
				att_addr_l  = att_start + hacd_axi_pkg::axi_addr_w'(off_l / 8) * 64;
				list_addr_l = list_start + hacd_axi_pkg::axi_addr_w'((head_l - 1) / 4) * 64;
				ar_cnt      = 0;
			end
			// read data channel never back-pressured once out of reset
			if ((arvalid || rvalid) && !rready) begin
				report_error("rready low during a table read");
			end
			if (arvalid && arready) begin
				ar_cnt++;
				if (ar_cnt == 1) begin
					check_val("ATT araddr", araddr, att_addr_l);
				end else if (ar_cnt == 2 && alloc_l) begin
					check_val("list araddr", araddr, list_addr_l);
				end else begin
					report_error("read issued that the lookup does not need");
				end
			end
			if (trnsl_valid) begin
				done_cnt++;
				if (alloc_l || bad_l) begin
					report_error("translation returned where none was due");
				end
				if (ar_cnt != 1) begin
					report_error("translation without exactly one table read");
				end
				if (beat_age != 2) begin
					report_error("translation not two cycles after the read beat");
				end
				check_val("trnsl_ppa", trnsl_ppa, way_l);
				check_val("trnsl_sts", trnsl_sts, sts_l);
				check_val("trnsl_allow", trnsl_allow, allow_l);
			end
			if (upd_valid && !upd_valid_q && beat_age != 2) begin
				report_error("upd_valid not two cycles after the list beat");
			end
			if (upd_valid && lkup_ready) begin
				report_error("lkup_ready high while an update is pending");
			end
			if (upd_valid && upd_ready) begin
				done_cnt++;
				if (!alloc_l) begin
					report_error("update issued where no allocation was due");
				end
				check_val("upd_att_id", upd_att_id, 16'(off_l + 1));
				check_val("upd_tol_id", upd_tol_id, head_l);
				check_val("upd_src", upd_src, hacd_tbl_pkg::lst_free);
				check_val("upd_dst", upd_dst, hacd_tbl_pkg::lst_uncomp);
				check_val("upd_entry", upd_entry, lent_l);
			end
			if (bus_error && !bad_l) begin
				report_error("bus_error raised without a bad response");
			end
			// after a bus error nothing may move
			if (bus_error && (lkup_ready || arvalid)) begin
				report_error("lkup_ready or arvalid seen after bus error");
			end
			if (rvalid && rready) begin
				beat_age = 0;
			end
			upd_valid_q = upd_valid;
		end
	end

endmodule

/* tests/pgrd_tb.sv */
// Testbench for the page-read manager.
// Runs a table of lookups against an AXI memory model and prints the verdict.
`timescale 1ns/10ps

module pgrd_tb;

	localparam logic [39:0] att_start  = 40'h00_0040_0000;
	localparam logic [39:0] list_start = 40'h00_0080_0000;
	localparam logic [27:0] hppa_base  = 28'h010_0000;
	localparam int unsigned n_cases    = 10;

	// one lookup, hppa given as an offset from hppa_base
	typedef struct packed {
		logic [27:0]            off;
		hacd_tbl_pkg::att_sts_t sts;
		logic [27:0]            way;
		hacd_tbl_pkg::list_id_t head;
		hacd_tbl_pkg::list_id_t tail;
		logic [27:0]            lppa;
		logic                   hold_upd;
		logic                   bad_resp;
	} case_t;

	// off, status, way, head, tail, list ppa, hold upd_ready, bad response
	localparam case_t cases [n_cases] = '{
		'{28'h000, hacd_tbl_pkg::sts_uncomp, 28'h123_4567, 16'd1, 16'd1, 28'h0, 1'b0, 1'b0},
		'{28'h007, hacd_tbl_pkg::sts_incomp, 28'h0ab_cdef, 16'd1, 16'd1, 28'h0, 1'b0, 1'b0},
		'{28'h008, hacd_tbl_pkg::sts_uncomp, 28'hfff_fff0, 16'd2, 16'd6, 28'h0, 1'b0, 1'b0},
		'{28'h01f, hacd_tbl_pkg::sts_comp, 28'h055_aa55, 16'd4, 16'd9, 28'h0, 1'b0, 1'b0},
		'{28'h023, hacd_tbl_pkg::sts_dalloc, 28'h0, 16'd5, 16'd9, 28'h200_0005, 1'b0, 1'b0},
		'{28'h02c, hacd_tbl_pkg::sts_dalloc, 28'h0, 16'd8, 16'd2, 28'h200_0008, 1'b1, 1'b0},
		'{28'h031, hacd_tbl_pkg::sts_dalloc, 28'h0, 16'd3, 16'd3, 28'h0, 1'b0, 1'b0},
		'{28'h045, hacd_tbl_pkg::sts_dalloc, 28'h0, 16'd14, 16'd20, 28'h200_000e, 1'b1, 1'b0},
		'{28'h012, hacd_tbl_pkg::sts_incomp, 28'h765_4321, 16'd7, 16'd7, 28'h0, 1'b0, 1'b0},
		'{28'h050, hacd_tbl_pkg::sts_uncomp, 28'h000_0bad, 16'd1, 16'd1, 28'h0, 1'b0, 1'b1}
	};

	logic                      clk_i;
	logic                      rst_ni;
	logic                      lkup_valid;
	logic [27:0]               lkup_hppa;
	logic                      lkup_ready;
	hacd_tbl_pkg::list_id_t    free_head;
	hacd_tbl_pkg::list_id_t    free_tail;
	logic [39:0]               araddr;
	logic                      arvalid;
	logic                      rready;
	// memory model outputs
	logic                      arready = 1'b0;
	logic                      rvalid  = 1'b0;
	logic [511:0]              rdata   = '0;
	logic [1:0]                rresp   = '0;
	logic                      rlast   = 1'b0;
	logic                      trnsl_valid;
	logic [27:0]               trnsl_ppa;
	hacd_tbl_pkg::att_sts_t    trnsl_sts;
	logic                      trnsl_allow;
	logic                      upd_valid;
	hacd_tbl_pkg::list_id_t    upd_att_id;
	hacd_tbl_pkg::list_id_t    upd_tol_id;
	hacd_tbl_pkg::list_sel_t   upd_src;
	hacd_tbl_pkg::list_sel_t   upd_dst;
	hacd_tbl_pkg::list_entry_t upd_entry;
	logic                      upd_ready;
	logic                      bus_error;
	hacd_tbl_pkg::att_sts_t    exp_sts;
	logic [27:0]               exp_way;
	hacd_tbl_pkg::list_entry_t exp_lentry;
	logic                      exp_bad;
	logic                      inject_err;
	int unsigned               err_cnt;
	int unsigned               done_cnt;
	int unsigned               tb_errs;
	// 64 lines of each table
	logic [511:0]              att_mem [64];
	logic [511:0]              list_mem [64];
	logic                      rd_pend;
	logic [39:0]               rd_addr_q;
	int unsigned               rd_wait;

	pgrd_top #(
		.att_start  (att_start),
		.list_start (list_start),
		.hppa_base  (hppa_base)
	) dut0 (.*);

	pgrd_mon #(
		.att_start  (att_start),
		.list_start (list_start),
		.hppa_base  (hppa_base)
	) mon0 (.*);

	always #20 clk_i = ~clk_i;

	// every word holds its own byte address
	task automatic fill_memory();
		logic [39:0] a;
		for (int l = 0; l < 64; l++) begin
			for (int w = 0; w < 8; w++) begin
				a = att_start + 40'(l * 64 + w * 8);
				att_mem[l][w*64 +: 64] = {8'hc3, 16'h0, a};
				a = list_start + 40'(l * 64 + w * 8);
				list_mem[l][w*64 +: 64] = {8'h3c, 16'h0, a};
			end
		end
	endtask

	function automatic logic [511:0] fetch_line(input logic [39:0] a);
		if (a >= att_start && a < att_start + 40'd4096) begin
			return att_mem[6'((a - att_start) >> 6)];
		end
		if (a >= list_start && a < list_start + 40'd4096) begin
			return list_mem[6'((a - list_start) >> 6)];
		end
		return {8{24'hdead00, a}};
	endfunction

	// AXI slave, random arready and random read latency
	always @(posedge clk_i) begin
		if (!rst_ni) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rlast   <= 1'b0;
			rd_pend <= 1'b0;
		end else begin
			arready <= ($urandom_range(0, 3) != 0);
			if (arvalid && arready && !rd_pend) begin
				rd_pend   <= 1'b1;
				rd_addr_q <= araddr;
				rd_wait   <= $urandom_range(0, 5);
			end
			if (rvalid && rready) begin
				rvalid <= 1'b0;
				rlast  <= 1'b0;
			end else if (rd_pend && !rvalid) begin
				if (rd_wait == 0) begin
					rvalid  <= 1'b1;
					rlast   <= 1'b1;
					rdata   <= fetch_line(rd_addr_q);
					rresp   <= inject_err ? hacd_axi_pkg::resp_slverr : hacd_axi_pkg::resp_okay;
					rd_pend <= 1'b0;
				end else begin
					rd_wait <= rd_wait - 1;
				end
			end
		end
	end

	// one lookup: load memory, issue the request, wait for its outcome
	task automatic run_case(input case_t c);
		hacd_tbl_pkg::att_entry_t  e;
		hacd_tbl_pkg::list_entry_t le;
		int unsigned               hold;
		logic                      done;
		e.way   = c.way;
		e.sts   = c.sts;
		e.rsvd  = '1;
		att_mem[c.off / 8][(c.off % 8) * 64 +: 64] = e;
		le.ppa  = c.lppa;
		le.next = c.head + 16'd1;
		le.prev = '0;
		le.rsvd = {40'h0, c.off};
		if (c.sts == hacd_tbl_pkg::sts_dalloc && c.head != c.tail) begin
			list_mem[(c.head - 1) / 4][((c.head - 1) % 4) * 128 +: 128] = le;
		end
		hold = $urandom_range(3, 12);
		@(posedge clk_i);
		lkup_valid <= 1'b1;
		lkup_hppa  <= hppa_base + c.off;
		free_head  <= c.head;
		free_tail  <= c.tail;
		upd_ready  <= !c.hold_upd;
		inject_err <= c.bad_resp;
		exp_sts    <= c.sts;
		exp_way    <= c.way;
		exp_lentry <= le;
		exp_bad    <= c.bad_resp;
		@(posedge clk_i);
		while (!lkup_ready) begin
			@(posedge clk_i);
		end
		lkup_valid <= 1'b0;
		done = 1'b0;
		while (!done) begin
			@(posedge clk_i);
			if (trnsl_valid || bus_error || (upd_valid && upd_ready)) begin
				done = 1'b1;
			end else if (upd_valid && !upd_ready) begin
				// release the stalled update after a random wait
				if (hold == 0) begin
					upd_ready <= 1'b1;
				end else begin
					hold--;
				end
			end
		end
		upd_ready <= 1'b1;
	endtask

	initial begin
		int unsigned total;
		void'($urandom(32'h5dee200c));
		clk_i      = 1'b0;
		rst_ni     = 1'b0;
		lkup_valid = 1'b0;
		lkup_hppa  = '0;
		free_head  = 16'd1;
		free_tail  = 16'd1;
		upd_ready  = 1'b1;
		inject_err = 1'b0;
		exp_sts    = hacd_tbl_pkg::sts_dalloc;
		exp_way    = '0;
		exp_lentry = '0;
		exp_bad    = 1'b0;
		tb_errs    = 0;
		fill_memory();
		repeat (10) @(posedge clk_i);
		rst_ni <= 1'b1;
		for (int i = 0; i < n_cases; i++) begin
			run_case(cases[i]);
		end
		// last case left a bus error, a pending request must stay refused
		lkup_valid <= 1'b1;
		repeat (20) @(posedge clk_i);
		lkup_valid <= 1'b0;
		@(posedge clk_i);
		if (!bus_error) begin
			$display("bus_error is not set at the end of the run");
			tb_errs++;
		end
		if (done_cnt != n_cases - 1) begin
			$display("%0d lookups completed, %0d were due", done_cnt, n_cases - 1);
			tb_errs++;
		end
		total = err_cnt + tb_errs + dut0.chk0.fail_cnt;
		$display("errors: checker %0d, assertions %0d, testbench %0d",
			err_cnt, dut0.chk0.fail_cnt, tb_errs);
		if (total == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// watchdog sized from the case count
	initial begin
		repeat (n_cases * 200 + 100) @(posedge clk_i);
		$display("timeout: run did not finish within %0d cycles", n_cases * 200 + 100);
		$display("Verification failed");
		$finish;
	end

endmodule

/* tb.f */
logic/hacd_axi_pkg.sv
logic/hacd_tbl_pkg.sv
logic/tbl_addr_gen.sv
logic/axi_rd_port.sv
logic/line_decode.sv
logic/pgrd_ctrl.sv
logic/pgrd_top.sv
tests/pgrd_chk.sv
tests/pgrd_mon.sv
tests/pgrd_tb.sv

/* Bender.yml */
package:
  name: pgrd

sources:
  - files:
      - logic/hacd_axi_pkg.sv
      - logic/hacd_tbl_pkg.sv
      - logic/tbl_addr_gen.sv
      - logic/axi_rd_port.sv
      - logic/line_decode.sv
      - logic/pgrd_ctrl.sv
      - logic/pgrd_top.sv
  - target: test
    files:
      - tests/pgrd_chk.sv
      - tests/pgrd_mon.sv
      - tests/pgrd_tb.sv
